/* verilog/ex_pkg.sv */
////////////////////
// Shared widths, data vector types and operation encodings
// for the execute stage and its functional units
////////////////////

package ex_pkg;

  // Datapath widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int SHAMT_W    = 5;

  // Divider iteration counter, one bit wider than the iteration index
  localparam int DIV_CNT_W  = 6;

  // Data word for operands, results and PCs
  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [SHAMT_W-1:0]    shamt_t;

  // Functional unit select
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_e;

  // ALU operations, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiply operations
  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;

  // Divide and remainder operations
  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

  // Divider FSM states
  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

endpackage

/* verilog/ex_alu.sv */
////////////////////
// Single-cycle ALU
// Add, subtract, logic, shifts, set-less-than and branch compares
////////////////////

`timescale 1ns/1ns

module ex_alu (
  input  ex_pkg::alu_op_e alu_op_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  ex_pkg::shamt_t shamt;
  ex_pkg::word_t  sum;
  ex_pkg::word_t  diff;
  logic           lt_signed;
  logic           lt_unsigned;
  logic           equal;

  // Shift amount from the low bits of operand b
  assign shamt = operand_b_i[ex_pkg::SHAMT_W-1:0];

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Magnitude and equality compares
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  ////////////////////
  // Compare result
  ////////////////////

  always_comb begin
    unique case (alu_op_i)
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_LT:   cmp_result_o = lt_signed;
      ex_pkg::ALU_SLTU,
      ex_pkg::ALU_LTU:  cmp_result_o = lt_unsigned;
      ex_pkg::ALU_GE:   cmp_result_o = !lt_signed;
      ex_pkg::ALU_GEU:  cmp_result_o = !lt_unsigned;
      ex_pkg::ALU_EQ:   cmp_result_o = equal;
      ex_pkg::ALU_NE:   cmp_result_o = !equal;
      // Non-compare operations
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Main result
  ////////////////////

  always_comb begin
    unique case (alu_op_i)
      ex_pkg::ALU_ADD:  result_o = sum;
      ex_pkg::ALU_SUB:  result_o = diff;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA:  result_o = ex_pkg::word_t'($signed(operand_a_i) >>> shamt);
      // Set-less-than returns the compare as 0 or 1
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};
      // Branch compares write nothing
      default:          result_o = '0;
    endcase
  end

endmodule

/* verilog/ex_mult.sv */
////////////////////
// Two-cycle multiplier
// MUL, MULH, MULHSU and MULHU with a registered 64-bit product
////////////////////

`timescale 1ns/1ns

module ex_mult (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            kill_i,
  input  ex_pkg::mul_op_e mul_op_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  input  logic            ready_i,
  output logic            ready_o,
  output logic            valid_o,
  output ex_pkg::word_t   result_o
);

  logic                               a_signed;
  logic                               b_signed;
  logic signed [ex_pkg::XLEN:0]       a_ext;
  logic signed [ex_pkg::XLEN:0]       b_ext;
  logic signed [2*ex_pkg::XLEN+1:0]   product;
  logic        [2*ex_pkg::XLEN-1:0]   prod_q;
  ex_pkg::mul_op_e                    op_q;
  logic                               valid_q;
  logic                               load;

  // Operand signedness per operation, MUL low half does not care
  assign a_signed = (mul_op_i != ex_pkg::MUL_MULHU);
  assign b_signed = (mul_op_i == ex_pkg::MUL_MUL) || (mul_op_i == ex_pkg::MUL_MULH);

  // One extra bit carries the sign or a zero
  assign a_ext   = {a_signed & operand_a_i[ex_pkg::XLEN-1], operand_a_i};
  assign b_ext   = {b_signed & operand_b_i[ex_pkg::XLEN-1], operand_b_i};
  assign product = a_ext * b_ext;

  // Capture on the first start cycle only
  assign load = start_i && !valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (kill_i || (valid_q && ready_i)) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end
  end

  // Product and operation held until the result leaves
  always_ff @(posedge clk) begin
    if (load) begin
      prod_q <= product[2*ex_pkg::XLEN-1:0];
      op_q   <= mul_op_i;
    end
  end

  assign valid_o  = valid_q;
  assign ready_o  = valid_q && ready_i;
  assign result_o = (op_q == ex_pkg::MUL_MUL) ? prod_q[ex_pkg::XLEN-1:0]
                                              : prod_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

  // Held instruction still matches the captured operation
  a_op_held: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && start_i |-> mul_op_i == op_q);

endmodule

/* verilog/ex_div.sv */
////////////////////
// Iterative restoring divider
// DIV, DIVU, REM and REMU, 32 iterations on absolute values
// Divide by zero and signed overflow finish early
////////////////////

`timescale 1ns/1ns

module ex_div (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  logic            kill_i,
  input  ex_pkg::div_op_e div_op_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  input  logic            ready_i,
  output logic            ready_o,
  output logic            valid_o,
  output ex_pkg::word_t   result_o
);

  ex_pkg::div_state_e           state_q;
  ex_pkg::div_op_e              op_q;
  logic [ex_pkg::DIV_CNT_W-1:0] cnt_q;
  ex_pkg::word_t                quot_q;
  ex_pkg::word_t                rem_q;
  ex_pkg::word_t                divisor_q;
  logic                         quot_neg_q;
  logic                         rem_neg_q;

  logic                         op_signed;
  logic                         a_neg;
  logic                         b_neg;
  ex_pkg::word_t                a_abs;
  ex_pkg::word_t                b_abs;
  logic                         div_zero;
  logic                         overflow;
  logic                         accept;
  logic [ex_pkg::XLEN:0]        rem_shift;
  logic [ex_pkg::XLEN:0]        rem_diff;
  logic                         rem_ge;
  ex_pkg::word_t                rem_next;

  ////////////////////
  // Operand setup
  ////////////////////

  assign op_signed = (div_op_i == ex_pkg::DIV_DIV) || (div_op_i == ex_pkg::DIV_REM);
  assign a_neg     = op_signed && operand_a_i[ex_pkg::XLEN-1];
  assign b_neg     = op_signed && operand_b_i[ex_pkg::XLEN-1];
  assign a_abs     = a_neg ? -operand_a_i : operand_a_i;
  assign b_abs     = b_neg ? -operand_b_i : operand_b_i;

  // RISC-V special cases
  assign div_zero = (operand_b_i == '0);
  assign overflow = op_signed && (operand_b_i == '1) &&
                    (operand_a_i == {1'b1, {(ex_pkg::XLEN-1){1'b0}}});

  assign accept = (state_q == ex_pkg::DIV_IDLE) && start_i;

  // One restoring step, next dividend bit shifted into the partial remainder
  assign rem_shift = {rem_q, quot_q[ex_pkg::XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};
  assign rem_ge    = rem_shift >= {1'b0, divisor_q};
  assign rem_next  = rem_ge ? rem_diff[ex_pkg::XLEN-1:0] : rem_shift[ex_pkg::XLEN-1:0];

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::DIV_IDLE;
      cnt_q   <= '0;
    end else if (kill_i) begin
      state_q <= ex_pkg::DIV_IDLE;
    end else begin
      unique case (state_q)
        ex_pkg::DIV_IDLE: begin
          if (start_i) begin
            cnt_q   <= '0;
            state_q <= (div_zero || overflow) ? ex_pkg::DIV_DONE : ex_pkg::DIV_RUN;
          end
        end
        ex_pkg::DIV_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          // Last of the XLEN iterations
          if (cnt_q == (ex_pkg::DIV_CNT_W)'(ex_pkg::XLEN - 1)) begin
            state_q <= ex_pkg::DIV_DONE;
          end
        end
        ex_pkg::DIV_DONE: begin
          if (ready_i) begin
            state_q <= ex_pkg::DIV_IDLE;
          end
        end
        default: state_q <= ex_pkg::DIV_IDLE;
      endcase
    end
  end

  // Datapath, quotient bits enter from the right as the dividend leaves
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= div_op_i;
      if (div_zero) begin
        quot_q     <= '1;
        rem_q      <= operand_a_i;
        quot_neg_q <= 1'b0;
        rem_neg_q  <= 1'b0;
      end else if (overflow) begin
        quot_q     <= operand_a_i;
        rem_q      <= '0;
        quot_neg_q <= 1'b0;
        rem_neg_q  <= 1'b0;
      end else begin
        quot_q     <= a_abs;
        rem_q      <= '0;
        divisor_q  <= b_abs;
        quot_neg_q <= a_neg ^ b_neg;
        rem_neg_q  <= a_neg;
      end
    end else if (state_q == ex_pkg::DIV_RUN) begin
      rem_q  <= rem_next;
      quot_q <= {quot_q[ex_pkg::XLEN-2:0], rem_ge};
    end
  end

  // Sign fix, remainder follows the dividend
  always_comb begin
    if ((op_q == ex_pkg::DIV_DIV) || (op_q == ex_pkg::DIV_DIVU)) begin
      result_o = quot_neg_q ? -quot_q : quot_q;
    end else begin
      result_o = rem_neg_q ? -rem_q : rem_q;
    end
  end

  assign valid_o = (state_q == ex_pkg::DIV_DONE);
  assign ready_o = valid_o && ready_i;

  // Stage issues one start per divide
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> state_q == ex_pkg::DIV_IDLE);

endmodule

/* verilog/ex_wb_reg.sv */
////////////////////
// Result select and execute-to-writeback register
////////////////////

`timescale 1ns/1ns

module ex_wb_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid_i,
  input  ex_pkg::unit_e     unit_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mul_result_i,
  input  ex_pkg::word_t     div_result_i,
  input  logic              rd_we_i,
  input  ex_pkg::reg_addr_t rd_addr_i,
  input  logic              wb_ready_i,
  output logic              wb_valid_o,
  output logic              wb_rd_we_o,
  output ex_pkg::reg_addr_t wb_rd_addr_o,
  output ex_pkg::word_t     wb_rd_data_o
);

  ex_pkg::word_t result;
  logic          load;

  // Result of the unit that holds the instruction
  always_comb begin
    unique case (unit_i)
      ex_pkg::UNIT_MUL: result = mul_result_i;
      ex_pkg::UNIT_DIV: result = div_result_i;
      default:          result = alu_result_i;
    endcase
  end

  assign load = ex_valid_i && wb_ready_i;

  // Valid and write enable, bubble when ready with nothing to load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o <= 1'b0;
      wb_rd_we_o <= 1'b0;
    end else if (load) begin
      wb_valid_o <= 1'b1;
      // Branches come with rd_we_i low
      wb_rd_we_o <= rd_we_i;
    end else if (wb_ready_i) begin
      wb_valid_o <= 1'b0;
      wb_rd_we_o <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      wb_rd_addr_o <= rd_addr_i;
      wb_rd_data_o <= result;
    end
  end

endmodule

/* verilog/ex_stage.sv */
////////////////////
// Execute stage top level
// Kill and halt gating, unit starts and handshakes, branch decision,
// ALU, multiplier, divider and the writeback register
////////////////////

`timescale 1ns/1ns

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              instr_valid_i,
  input  logic              kill_i,
  input  logic              halt_i,
  input  logic              dit_en_i,
  input  ex_pkg::unit_e     unit_i,
  input  ex_pkg::alu_op_e   alu_op_i,
  input  ex_pkg::mul_op_e   mul_op_i,
  input  ex_pkg::div_op_e   div_op_i,
  input  ex_pkg::word_t     operand_a_i,
  input  ex_pkg::word_t     operand_b_i,
  input  logic              rd_we_i,
  input  ex_pkg::reg_addr_t rd_addr_i,
  input  logic              is_branch_i,
  input  ex_pkg::word_t     branch_target_i,
  input  ex_pkg::word_t     fallthrough_pc_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic              branch_decision_o,
  output ex_pkg::word_t     branch_target_o,
  output logic              wb_valid_o,
  output logic              wb_rd_we_o,
  output ex_pkg::reg_addr_t wb_rd_addr_o,
  output ex_pkg::word_t     wb_rd_data_o
);

  logic          instr_valid;
  logic          mul_start;
  logic          div_start;
  logic          div_busy_q;
  logic          unit_ready_in;
  logic          unit_ready;
  logic          ex_valid;
  ex_pkg::word_t alu_result;
  logic          alu_cmp;
  logic          mul_ready;
  logic          mul_valid;
  ex_pkg::word_t mul_result;
  logic          div_ready;
  logic          div_valid;
  ex_pkg::word_t div_result;
  logic          branch_valid;

  // Instruction after kill and halt
  assign instr_valid = instr_valid_i && !kill_i && !halt_i;

  // Multiplier start is a level and the divider gets one start per instruction
  assign mul_start = instr_valid && (unit_i == ex_pkg::UNIT_MUL);
  assign div_start = instr_valid && (unit_i == ex_pkg::UNIT_DIV) && !div_busy_q;

  // Results must not leave a unit while halted
  assign unit_ready_in = wb_ready_i && !halt_i;

  // Divide issued and not yet left the stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_busy_q <= 1'b0;
    end else if (kill_i || (instr_valid_i && ex_ready_o)) begin
      div_busy_q <= 1'b0;
    end else if (div_start) begin
      div_busy_q <= 1'b1;
    end
  end

  ////////////////////
  // Stage handshake
  ////////////////////

  // ALU is always valid and ready on downstream ready
  always_comb begin
    unique case (unit_i)
      ex_pkg::UNIT_MUL: begin
        unit_ready = mul_ready;
        ex_valid   = instr_valid && mul_valid;
      end
      ex_pkg::UNIT_DIV: begin
        unit_ready = div_ready;
        ex_valid   = instr_valid && div_valid;
      end
      default: begin
        unit_ready = wb_ready_i;
        ex_valid   = instr_valid;
      end
    endcase
  end

  // Kill drops the instruction at once and halt holds it
  assign ex_ready_o = kill_i || (unit_ready && !halt_i);

  ////////////////////
  // Branch decision
  ////////////////////

  assign branch_valid = instr_valid_i && !kill_i && is_branch_i;

  // With DIT every branch is taken and not-taken goes to the sequential PC
  always_comb begin
    if (dit_en_i) begin
      branch_decision_o = branch_valid;
      branch_target_o   = alu_cmp ? branch_target_i : fallthrough_pc_i;
    end else begin
      branch_decision_o = branch_valid && alu_cmp;
      branch_target_o   = branch_target_i;
    end
  end

  // Functional units
  ex_alu u_alu (
    .alu_op_i     (alu_op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (mul_start),
    .kill_i      (kill_i),
    .mul_op_i    (mul_op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ready_i     (unit_ready_in),
    .ready_o     (mul_ready),
    .valid_o     (mul_valid),
    .result_o    (mul_result)
  );

  ex_div u_div (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (div_start),
    .kill_i      (kill_i),
    .div_op_i    (div_op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ready_i     (unit_ready_in),
    .ready_o     (div_ready),
    .valid_o     (div_valid),
    .result_o    (div_result)
  );

  // Writeback register
  ex_wb_reg u_wb_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid),
    .unit_i       (unit_i),
    .alu_result_i (alu_result),
    .mul_result_i (mul_result),
    .div_result_i (div_result),
    .rd_we_i      (rd_we_i),
    .rd_addr_i    (rd_addr_i),
    .wb_ready_i   (wb_ready_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_we_o   (wb_rd_we_o),
    .wb_rd_addr_o (wb_rd_addr_o),
    .wb_rd_data_o (wb_rd_data_o)
  );

  // Kill returns both units to idle by the next cycle
  a_kill_no_valid: assert property (@(posedge clk) disable iff (!rst_n)
    kill_i |=> !mul_valid && !div_valid);

endmodule

/* dv/ex_ref_model.svh */
////////////////////
// Reference model of the execute stage
// ALU, multiply and divide results per RISC-V rules
// and the branch decision with and without DIT
////////////////////

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Compare outcome for set-less-than and branch compares
function automatic logic alu_compare(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                                     input ex_pkg::word_t b);
  // Sign bits flipped so that an unsigned compare orders signed values
  logic [31:0] sa;
  logic [31:0] sb;
  sa = a ^ 32'h8000_0000;
  sb = b ^ 32'h8000_0000;
  case (op)
    ex_pkg::ALU_SLT, ex_pkg::ALU_LT:   return sa < sb;
    ex_pkg::ALU_SLTU, ex_pkg::ALU_LTU: return a < b;
    ex_pkg::ALU_GE:                    return !(sa < sb);
    ex_pkg::ALU_GEU:                   return !(a < b);
    ex_pkg::ALU_EQ:                    return a == b;
    ex_pkg::ALU_NE:                    return a != b;
    default:                           return 1'b0;
  endcase
endfunction

function automatic ex_pkg::word_t alu_expect(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
                                             input ex_pkg::word_t b);
  logic [4:0]    sh;
  ex_pkg::word_t fill;
  sh = b[4:0];
  // Ones shifted in from the top for a negative operand
  fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
  case (op)
    ex_pkg::ALU_ADD:                   return a + b;
    ex_pkg::ALU_SUB:                   return a - b;
    ex_pkg::ALU_AND:                   return a & b;
    ex_pkg::ALU_OR:                    return a | b;
    ex_pkg::ALU_XOR:                   return a ^ b;
    ex_pkg::ALU_SLL:                   return a << sh;
    ex_pkg::ALU_SRL:                   return a >> sh;
    ex_pkg::ALU_SRA:                   return (a >> sh) | fill;
    ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU: return {31'b0, alu_compare(op, a, b)};
    // Branch compares leave no result
    default:                           return 32'h0;
  endcase
endfunction

// Full 64-bit product of the extended operands, low or high half
function automatic ex_pkg::word_t mul_expect(input ex_pkg::mul_op_e op, input ex_pkg::word_t a,
                                             input ex_pkg::word_t b);
  logic [63:0] ea;
  logic [63:0] eb;
  logic [63:0] prod;
  ea   = (op == ex_pkg::MUL_MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
  eb   = (op == ex_pkg::MUL_MULHSU || op == ex_pkg::MUL_MULHU) ? {32'h0, b} : {{32{b[31]}}, b};
  prod = ea * eb;
  return (op == ex_pkg::MUL_MUL) ? prod[31:0] : prod[63:32];
endfunction

function automatic ex_pkg::word_t div_expect(input ex_pkg::div_op_e op, input ex_pkg::word_t a,
                                             input ex_pkg::word_t b);
  logic   sgn;
  logic   quot;
  longint na;
  longint nb;
  longint q;
  longint r;
  sgn  = (op == ex_pkg::DIV_DIV) || (op == ex_pkg::DIV_REM);
  quot = (op == ex_pkg::DIV_DIV) || (op == ex_pkg::DIV_DIVU);
  // Divide by zero: all ones quotient, dividend as remainder
  if (b == 32'h0) begin
    return quot ? 32'hffff_ffff : a;
  end
  na = sgn ? longint'($signed(a)) : longint'({32'h0, a});
  nb = sgn ? longint'($signed(b)) : longint'({32'h0, b});
  // 64-bit math truncates toward zero; overflow wraps back to the dividend
  q = na / nb;
  r = na % nb;
  return quot ? q[31:0] : r[31:0];
endfunction

function automatic ex_pkg::word_t exec_result(input ex_pkg::unit_e unit,
    input ex_pkg::alu_op_e aop, input ex_pkg::mul_op_e mop, input ex_pkg::div_op_e dop,
    input ex_pkg::word_t a, input ex_pkg::word_t b);
  case (unit)
    ex_pkg::UNIT_MUL: return mul_expect(mop, a, b);
    ex_pkg::UNIT_DIV: return div_expect(dop, a, b);
    default:          return alu_expect(aop, a, b);
  endcase
endfunction

// Decision in bit 32, target below
function automatic logic [32:0] branch_expect(input ex_pkg::alu_op_e op, input ex_pkg::word_t a,
    input ex_pkg::word_t b, input logic dit, input ex_pkg::word_t target,
    input ex_pkg::word_t fallthrough);
  logic taken;
  taken = alu_compare(op, a, b);
  // DIT: always taken, not-taken goes to the sequential PC
  if (dit) begin
    return {1'b1, taken ? target : fallthrough};
  end
  return {taken, target};
endfunction

`endif

/* dv/tb_ex_stage.sv */
////////////////////
// Testbench for the execute stage
// Clock, reset, stimulus with back-pressure, writeback scoreboard,
// check task and cycle timeout
////////////////////

`timescale 1ns/1ns

module tb_ex_stage;

  localparam integer SEED     = 32'h8c62_c8d8;
  localparam int N_RAND_ALU   = 8;
  localparam int N_BRANCH     = 10;
  localparam int N_RAND_MUL   = 12;
  localparam int N_RAND_DIV   = 8;
  localparam int N_MIXED      = 200;
  localparam int N_KILL       = 10;
  localparam int TEST_COUNT   = 10 * (9 + N_RAND_ALU) + 12 * N_BRANCH + 4 * (9 + N_RAND_MUL) +
                                4 * (9 + N_RAND_DIV) + N_MIXED + N_KILL;
  // A divide plus back-pressure stays well under 40 cycles
  localparam int TIMEOUT_CYCLES = TEST_COUNT * 40 + 500;

  logic              clk;
  logic              rst_n;
  logic              instr_valid_i;
  logic              kill_i;
  logic              halt_i;
  logic              dit_en_i;
  ex_pkg::unit_e     unit_i;
  ex_pkg::alu_op_e   alu_op_i;
  ex_pkg::mul_op_e   mul_op_i;
  ex_pkg::div_op_e   div_op_i;
  ex_pkg::word_t     operand_a_i;
  ex_pkg::word_t     operand_b_i;
  logic              rd_we_i;
  ex_pkg::reg_addr_t rd_addr_i;
  logic              is_branch_i;
  ex_pkg::word_t     branch_target_i;
  ex_pkg::word_t     fallthrough_pc_i;
  logic              wb_ready_i;
  logic              ex_ready_o;
  logic              branch_decision_o;
  ex_pkg::word_t     branch_target_o;
  logic              wb_valid_o;
  logic              wb_rd_we_o;
  ex_pkg::reg_addr_t wb_rd_addr_o;
  ex_pkg::word_t     wb_rd_data_o;

  integer      seed;
  int          cycle_count;
  // Expected writebacks in issue order as {we, addr, data}
  logic [37:0] exp_q[$];
  logic [37:0] exp_entry;

  `include "ex_ref_model.svh"

  ex_stage u_dut (.*);

  always #5 clk = ~clk;

  ////////////////////
  // Checks and failure exit
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, got, expected));
    end
  endtask

  // Scoreboard pops one entry per writeback handshake
  always @(posedge clk) begin
    if (rst_n && wb_valid_o && wb_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("writeback seen with no instruction outstanding");
      end else begin
        exp_entry = exp_q.pop_front();
        check_value("wb_rd_we_o", 32'(wb_rd_we_o), 32'(exp_entry[37]));
        check_value("wb_rd_addr_o", 32'(wb_rd_addr_o), 32'(exp_entry[36:32]));
        check_value("wb_rd_data_o", wb_rd_data_o, exp_entry[31:0]);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Step to the next falling edge with a random downstream ready
  // keep=0 drops the instruction
  task automatic advance(input logic keep);
    @(negedge clk);
    if (!keep) begin
      instr_valid_i = 1'b0;
      kill_i        = 1'b0;
      halt_i        = 1'b0;
    end
    wb_ready_i = ({$random(seed)} % 4) != 0;
  endtask

  function automatic ex_pkg::word_t edge_value(input int idx);
    case (idx)
      0:       return 32'h0;
      1:       return 32'hffff_ffff;
      default: return 32'h8000_0000;
    endcase
  endfunction

  // Present one instruction and hold it until accepted
  // A negative kill_at never kills
  task automatic issue(input ex_pkg::unit_e unit, input logic [3:0] op, input ex_pkg::word_t a,
                       input ex_pkg::word_t b, input logic dit, input int kill_at);
    logic        br;
    logic [32:0] br_exp;
    int          held;
    br = (unit == ex_pkg::UNIT_ALU) && (op >= 4'(ex_pkg::ALU_EQ));
    advance(1'b0);
    unit_i           = unit;
    alu_op_i         = ex_pkg::alu_op_e'(op);
    mul_op_i         = ex_pkg::mul_op_e'(op[1:0]);
    div_op_i         = ex_pkg::div_op_e'(op[1:0]);
    operand_a_i      = a;
    operand_b_i      = b;
    rd_we_i          = !br;
    rd_addr_i        = 5'($random(seed));
    is_branch_i      = br;
    dit_en_i         = dit;
    branch_target_i  = $random(seed);
    fallthrough_pc_i = $random(seed);
    kill_i           = (kill_at == 0);
    instr_valid_i    = 1'b1;
    if (kill_at < 0) begin
      exp_q.push_back({rd_we_i, rd_addr_i, exec_result(unit, alu_op_i, mul_op_i, div_op_i, a, b)});
    end
    #1;
    // Branch outputs while the instruction is held
    if (br && kill_at < 0) begin
      br_exp = branch_expect(alu_op_i, a, b, dit, branch_target_i, fallthrough_pc_i);
      check_value("branch_decision_o", 32'(branch_decision_o), 32'(br_exp[32]));
      check_value("branch_target_o", branch_target_o, br_exp[31:0]);
    end
    held = 0;
    while (!ex_ready_o) begin
      advance(1'b1);
      held++;
      kill_i = (kill_at >= 0) && (held >= kill_at);
      // Occasional halt while waiting
      halt_i = !kill_i && ({$random(seed)} % 8 == 0);
      #1;
    end
  endtask

  // Edge pairs then random operands with every other divisor made small
  task automatic sweep(input ex_pkg::unit_e unit, input int op_first, input int op_last,
                       input int n_rand);
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    for (int op = op_first; op <= op_last; op++) begin
      for (int i = 0; i < 9; i++) begin
        issue(unit, 4'(op), edge_value(i / 3), edge_value(i % 3), 1'b0, -1);
      end
      for (int i = 0; i < n_rand; i++) begin
        a = $random(seed);
        b = $random(seed);
        if (i % 2 == 1) begin
          b = b >> 20;
        end
        issue(unit, 4'(op), a, b, 1'b0, -1);
      end
    end
  endtask

  task automatic branch_sweep();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    for (int op = 10; op < 16; op++) begin
      for (int d = 0; d < 2; d++) begin
        for (int i = 0; i < N_BRANCH; i++) begin
          a = $random(seed);
          b = (i % 3 == 0) ? a : $random(seed);
          issue(ex_pkg::UNIT_ALU, 4'(op), a, b, 1'(d), -1);
        end
      end
    end
  endtask

  // Random unit, operation and DIT mix
  task automatic mixed_run();
    ex_pkg::unit_e unit;
    logic [3:0]    op;
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    logic          dit;
    for (int i = 0; i < N_MIXED; i++) begin
      unit = ex_pkg::unit_e'(2'({$random(seed)} % 3));
      op   = 4'($random(seed));
      a    = $random(seed);
      b    = $random(seed);
      dit  = 1'($random(seed));
      issue(unit, op, a, b, dit, -1);
    end
  endtask

  // Killed instructions each followed by a normal one of the same unit
  task automatic kill_checks();
    issue(ex_pkg::UNIT_ALU, 4'(ex_pkg::ALU_ADD), 32'd5, 32'd7, 1'b0, 0);
    issue(ex_pkg::UNIT_ALU, 4'(ex_pkg::ALU_SUB), 32'd5, 32'd7, 1'b0, -1);
    issue(ex_pkg::UNIT_MUL, 4'(ex_pkg::MUL_MUL), 32'd9, 32'd11, 1'b0, 0);
    // Killed with the product already registered
    issue(ex_pkg::UNIT_MUL, 4'(ex_pkg::MUL_MULH), 32'hdead_beef, 32'h1234_5678, 1'b0, 1);
    issue(ex_pkg::UNIT_MUL, 4'(ex_pkg::MUL_MULHU), 32'hdead_beef, 32'h1234_5678, 1'b0, -1);
    issue(ex_pkg::UNIT_DIV, 4'(ex_pkg::DIV_DIV), 32'd1000, 32'd0, 1'b0, 0);
    // Divide dropped in the middle of its iterations
    issue(ex_pkg::UNIT_DIV, 4'(ex_pkg::DIV_DIV), 32'hffff_0000, 32'd7, 1'b0, 10);
    issue(ex_pkg::UNIT_DIV, 4'(ex_pkg::DIV_REM), 32'hffff_0000, 32'd7, 1'b0, -1);
    issue(ex_pkg::UNIT_ALU, 4'(ex_pkg::ALU_EQ), 32'd3, 32'd3, 1'b1, 0);
    issue(ex_pkg::UNIT_ALU, 4'(ex_pkg::ALU_NE), 32'd3, 32'd4, 1'b1, -1);
  endtask

  initial begin
    seed             = SEED;
    cycle_count      = 0;
    clk              = 1'b0;
    rst_n            = 1'b0;
    instr_valid_i    = 1'b0;
    kill_i           = 1'b0;
    halt_i           = 1'b0;
    dit_en_i         = 1'b0;
    unit_i           = ex_pkg::UNIT_ALU;
    alu_op_i         = ex_pkg::ALU_ADD;
    mul_op_i         = ex_pkg::MUL_MUL;
    div_op_i         = ex_pkg::DIV_DIV;
    operand_a_i      = '0;
    operand_b_i      = '0;
    rd_we_i          = 1'b0;
    rd_addr_i        = '0;
    is_branch_i      = 1'b0;
    branch_target_i  = '0;
    fallthrough_pc_i = '0;
    wb_ready_i       = 1'b0;
    repeat (8) @(negedge clk);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);
    rst_n = 1'b1;
    advance(1'b0);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'h0);

    sweep(ex_pkg::UNIT_ALU, 0, 9, N_RAND_ALU);
    branch_sweep();
    sweep(ex_pkg::UNIT_MUL, 0, 3, N_RAND_MUL);
    sweep(ex_pkg::UNIT_DIV, 0, 3, N_RAND_DIV);
    kill_checks();
    mixed_run();

    // Drain the queue and idle a few cycles to catch stray writebacks
    while (exp_q.size() != 0) begin
      advance(1'b0);
    end
    repeat (5) advance(1'b0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* src.f */
+incdir+dv
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_div.sv
verilog/ex_wb_reg.sv
verilog/ex_stage.sv
dv/tb_ex_stage.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := tb_ex_stage
FILELIST := src.f
BUILD    := obj_dir
LOG      := sim.log

BIN     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "STATUS: FAIL" $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
